/* src/dm_consts.svh */
`ifndef DM_CONSTS_SVH
`define DM_CONSTS_SVH

// --------------------------------------------------
// debug module sizing
// --------------------------------------------------
`define DM_NR_HARTS 4
`define DM_DATA_COUNT 2

// debug spec 0.13
`define DM_VERSION 4'd2

// --------------------------------------------------
// DMI register map (7-bit addresses)
// --------------------------------------------------
`define DM_ADDR_DATA0 7'h04
`define DM_ADDR_DMCONTROL 7'h10
`define DM_ADDR_DMSTATUS 7'h11
`define DM_ADDR_ABSTRACTCS 7'h16
`define DM_ADDR_COMMAND 7'h17
`define DM_ADDR_ABSTRACTAUTO 7'h18
`define DM_ADDR_HALTSUM0 7'h40

// DMI request opcodes
`define DM_OP_NOP 2'd0
`define DM_OP_READ 2'd1
`define DM_OP_WRITE 2'd2

// abstract command error codes
`define DM_CMDERR_NONE 3'd0
`define DM_CMDERR_BUSY 3'd1

`endif

/* src/dm_pkg.sv */
`include "dm_consts.svh"

package dm_pkg;

  // DMI request fields
  typedef logic [6:0] dmi_addr_t;
  typedef logic [1:0] dmi_op_t;

  // register or data word
  typedef logic [31:0] dm_word_t;

  // hart selection and per hart vectors
  typedef logic [9:0] hart_sel_t;
  typedef logic [`DM_NR_HARTS-1:0] hart_vec_t;

  // abstract command state
  typedef logic [2:0] cmderr_t;
  typedef logic [$clog2(`DM_DATA_COUNT)-1:0] data_idx_t;
  typedef logic [`DM_DATA_COUNT*32-1:0] data_bus_t;

  // request decode, stalls while the response queue is full
  typedef enum logic {
    DEC_IDLE,
    DEC_STALL
  } decode_state_e;

endpackage

/* src/dm_resp_fifo.sv */
`timescale 1ns/1ps

module dm_resp_fifo (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  dm_pkg::dm_word_t data_i,
  input  logic             pop_i,
  output dm_pkg::dm_word_t data_o,
  output logic             full_o,
  output logic             empty_o
);

  dm_pkg::dm_word_t mem_q [2];
  logic             wptr_q;
  logic             rptr_q;
  logic [1:0]       count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == 2'd2);
  assign empty_o = (count_q == 2'd0);

  // push while full and pop while empty are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign data_o = mem_q[rptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= 1'b0;
      rptr_q  <= 1'b0;
      count_q <= 2'd0;
    end else begin
      if (do_push) begin
        wptr_q <= ~wptr_q;
      end
      if (do_pop) begin
        rptr_q <= ~rptr_q;
      end
      count_q <= count_q + {1'b0, do_push} - {1'b0, do_pop};
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= data_i;
    end
  end

endmodule

/* src/dm_dmi_decode.sv */
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_dmi_decode (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              dmi_req_valid_i,
  input  dm_pkg::dmi_addr_t dmi_req_addr_i,
  input  dm_pkg::dmi_op_t   dmi_req_op_i,
  input  dm_pkg::dm_word_t  dmi_req_data_i,
  input  logic              queue_full_i,
  input  dm_pkg::dm_word_t  dmcontrol_i,
  input  dm_pkg::dm_word_t  dmstatus_i,
  input  dm_pkg::dm_word_t  haltsum0_i,
  input  dm_pkg::dm_word_t  abstractcs_i,
  input  dm_pkg::dm_word_t  abstractauto_i,
  input  dm_pkg::data_bus_t data_i,
  output logic              dmi_req_ready_o,
  output logic              wr_dmcontrol_o,
  output logic              wr_abstractcs_o,
  output logic              wr_command_o,
  output logic              wr_abstractauto_o,
  output logic              wr_data_o,
  output logic              rd_data_o,
  output dm_pkg::data_idx_t data_idx_o,
  output dm_pkg::dm_word_t  wdata_o,
  output logic              push_o,
  output dm_pkg::dm_word_t  push_data_o
);

  dm_pkg::decode_state_e state_d, state_q;
  dm_pkg::dmi_addr_t     addr_off;
  dm_pkg::dm_word_t      rdata;
  logic                  accept;
  logic                  is_read;
  logic                  is_write;
  logic                  is_data;

  // one response slot must be free to take a request
  assign dmi_req_ready_o = ~queue_full_i;
  assign accept          = dmi_req_valid_i & dmi_req_ready_o;
  assign is_read         = accept & (dmi_req_op_i == `DM_OP_READ);
  assign is_write        = accept & (dmi_req_op_i == `DM_OP_WRITE);

  // data0 .. dataN-1 window
  assign addr_off   = dmi_req_addr_i - `DM_ADDR_DATA0;
  assign is_data    = (dmi_req_addr_i >= `DM_ADDR_DATA0) && (addr_off < `DM_DATA_COUNT);
  assign data_idx_o = dm_pkg::data_idx_t'(addr_off);
  assign wdata_o    = dmi_req_data_i;

  assign wr_dmcontrol_o    = is_write & (dmi_req_addr_i == `DM_ADDR_DMCONTROL);
  assign wr_abstractcs_o   = is_write & (dmi_req_addr_i == `DM_ADDR_ABSTRACTCS);
  assign wr_command_o      = is_write & (dmi_req_addr_i == `DM_ADDR_COMMAND);
  assign wr_abstractauto_o = is_write & (dmi_req_addr_i == `DM_ADDR_ABSTRACTAUTO);
  assign wr_data_o         = is_write & is_data;
  assign rd_data_o         = is_read & is_data;

  // --------------------------------------------------
  // read mux, command and unmapped addresses read zero
  // --------------------------------------------------
  always_comb begin
    rdata = '0;
    if (is_data) begin
      rdata = data_i[32*data_idx_o +: 32];
    end else begin
      case (dmi_req_addr_i)
        `DM_ADDR_DMCONTROL:    rdata = dmcontrol_i;
        `DM_ADDR_DMSTATUS:     rdata = dmstatus_i;
        `DM_ADDR_ABSTRACTCS:   rdata = abstractcs_i;
        `DM_ADDR_ABSTRACTAUTO: rdata = abstractauto_i;
        `DM_ADDR_HALTSUM0:     rdata = haltsum0_i;
        default:               rdata = '0;
      endcase
    end
  end

  // every accepted request gets exactly one response word
  assign push_o = accept;

  always_comb begin
    case (dmi_req_op_i)
      `DM_OP_READ:              push_data_o = rdata;
      `DM_OP_NOP, `DM_OP_WRITE: push_data_o = '0;
      default:                  push_data_o = '0;
    endcase
  end

  // stall tracking, a request waits on a full queue
  assign state_d = (dmi_req_valid_i && queue_full_i) ? dm_pkg::DEC_STALL : dm_pkg::DEC_IDLE;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= dm_pkg::DEC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* src/dm_hart_ctrl.sv */
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_hart_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              wr_dmcontrol_i,
  input  dm_pkg::dm_word_t  wdata_i,
  input  dm_pkg::hart_vec_t halted_i,
  input  dm_pkg::hart_vec_t unavailable_i,
  input  dm_pkg::hart_vec_t resumeack_i,
  output dm_pkg::dm_word_t  dmcontrol_o,
  output dm_pkg::dm_word_t  dmstatus_o,
  output dm_pkg::dm_word_t  haltsum0_o,
  output dm_pkg::hart_vec_t haltreq_o,
  output dm_pkg::hart_vec_t resumereq_o,
  output logic              clear_resumeack_o,
  output logic              ndmreset_o,
  output logic              dmactive_o
);

  localparam int unsigned HartIdxW = (`DM_NR_HARTS > 1) ? $clog2(`DM_NR_HARTS) : 1;

  logic              dmactive_d, dmactive_q;
  logic              ndmreset_d, ndmreset_q;
  logic              haltreq_d, haltreq_q;
  logic              resumereq_d, resumereq_q;
  dm_pkg::hart_sel_t hartsel_d, hartsel_q;
  dm_pkg::hart_vec_t havereset_d, havereset_q;

  logic [HartIdxW-1:0] hart_idx;
  logic                hart_exists;
  logic                sel_halted;
  logic                sel_unavail;
  logic                sel_resumeack;
  logic                sel_havereset;

  // --------------------------------------------------
  // selected hart
  // --------------------------------------------------
  assign hart_idx      = hartsel_q[HartIdxW-1:0];
  assign hart_exists   = (hartsel_q < dm_pkg::hart_sel_t'(`DM_NR_HARTS));
  assign sel_halted    = hart_exists & halted_i[hart_idx];
  assign sel_unavail   = hart_exists & unavailable_i[hart_idx];
  assign sel_resumeack = hart_exists & resumeack_i[hart_idx];
  assign sel_havereset = hart_exists & havereset_q[hart_idx];

  // hasel, hartreset and ackhavereset always read zero
  assign dmcontrol_o = {haltreq_q, resumereq_q, 4'b0, hartsel_q, 14'b0, ndmreset_q, dmactive_q};

  always_comb begin
    dmstatus_o       = '0;
    dmstatus_o[3:0]  = `DM_VERSION;
    // no authentication
    dmstatus_o[7]    = 1'b1;
    // halted, running and unavailable are exclusive
    dmstatus_o[8]    = sel_halted & ~sel_unavail;
    dmstatus_o[9]    = sel_halted & ~sel_unavail;
    dmstatus_o[10]   = hart_exists & ~sel_halted & ~sel_unavail;
    dmstatus_o[11]   = hart_exists & ~sel_halted & ~sel_unavail;
    dmstatus_o[12]   = sel_unavail;
    dmstatus_o[13]   = sel_unavail;
    dmstatus_o[14]   = ~hart_exists;
    dmstatus_o[15]   = ~hart_exists;
    dmstatus_o[16]   = sel_resumeack;
    dmstatus_o[17]   = sel_resumeack;
    dmstatus_o[18]   = sel_havereset;
    dmstatus_o[19]   = sel_havereset;
  end

  // only the first 32 harts are summarized here
  assign haltsum0_o = (hartsel_q < 10'd32) ? {{(32-`DM_NR_HARTS){1'b0}}, halted_i} : '0;

  // requests go to the selected hart only
  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (hart_exists) begin
      haltreq_o[hart_idx]   = haltreq_q;
      resumereq_o[hart_idx] = resumereq_q;
    end
  end

  assign ndmreset_o = ndmreset_q;
  assign dmactive_o = dmactive_q;

  // --------------------------------------------------
  // dmcontrol update
  // --------------------------------------------------
  always_comb begin
    dmactive_d        = dmactive_q;
    ndmreset_d        = ndmreset_q;
    haltreq_d         = haltreq_q;
    resumereq_d       = resumereq_q;
    hartsel_d         = hartsel_q;
    havereset_d       = havereset_q;
    clear_resumeack_o = 1'b0;
    if (wr_dmcontrol_i) begin
      dmactive_d  = wdata_i[0];
      ndmreset_d  = wdata_i[1];
      hartsel_d   = wdata_i[25:16];
      resumereq_d = wdata_i[30];
      haltreq_d   = wdata_i[31];
      // ackhavereset acts on the hart selected before this write
      if (wdata_i[28] && hart_exists) begin
        havereset_d[hart_idx] = 1'b0;
      end
      if (wdata_i[30] && !resumereq_q) begin
        clear_resumeack_o = 1'b1;
      end
    end
    if (resumereq_q && sel_resumeack) begin
      resumereq_d = 1'b0;
    end
    if (ndmreset_q) begin
      havereset_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmactive_q  <= 1'b0;
      ndmreset_q  <= 1'b0;
      haltreq_q   <= 1'b0;
      resumereq_q <= 1'b0;
      hartsel_q   <= '0;
      havereset_q <= '1;
    end else begin
      havereset_q <= havereset_d;
      dmactive_q  <= dmactive_d;
      // inactive module keeps everything else cleared
      if (!dmactive_q) begin
        ndmreset_q  <= 1'b0;
        haltreq_q   <= 1'b0;
        resumereq_q <= 1'b0;
        hartsel_q   <= '0;
      end else begin
        ndmreset_q  <= ndmreset_d;
        haltreq_q   <= haltreq_d;
        resumereq_q <= resumereq_d;
        hartsel_q   <= hartsel_d;
      end
    end
  end

endmodule

/* src/dm_abstract_cmd.sv */
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_abstract_cmd (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              dmactive_i,
  input  logic              wr_abstractcs_i,
  input  logic              wr_command_i,
  input  logic              wr_abstractauto_i,
  input  logic              wr_data_i,
  input  logic              rd_data_i,
  input  dm_pkg::data_idx_t data_idx_i,
  input  dm_pkg::dm_word_t  wdata_i,
  input  logic              cmdbusy_i,
  input  logic              cmderror_valid_i,
  input  dm_pkg::cmderr_t   cmderror_i,
  input  dm_pkg::data_bus_t data_i,
  input  logic              data_valid_i,
  output dm_pkg::dm_word_t  abstractcs_o,
  output dm_pkg::dm_word_t  abstractauto_o,
  output dm_pkg::dm_word_t  cmd_o,
  output logic              cmd_valid_o,
  output dm_pkg::data_bus_t data_o
);

  dm_pkg::cmderr_t           cmderr_d, cmderr_q;
  dm_pkg::dm_word_t          command_d, command_q;
  logic                      cmd_valid_d, cmd_valid_q;
  logic [`DM_DATA_COUNT-1:0] autoexec_d, autoexec_q;
  dm_pkg::data_bus_t         data_d, data_q;
  logic                      any_access;

  // accesses that collide with a running command
  assign any_access = wr_abstractcs_i | wr_command_i | wr_abstractauto_i |
                      wr_data_i | rd_data_i;

  // --------------------------------------------------
  // register views
  // --------------------------------------------------
  assign abstractcs_o   = {19'b0, cmdbusy_i, 1'b0, cmderr_q, 4'b0, 4'(`DM_DATA_COUNT)};
  assign abstractauto_o = {{(32-`DM_DATA_COUNT){1'b0}}, autoexec_q};
  assign cmd_o          = command_q;
  assign cmd_valid_o    = cmd_valid_q;
  assign data_o         = data_q;

  always_comb begin
    cmderr_d    = cmderr_q;
    command_d   = command_q;
    cmd_valid_d = 1'b0;
    autoexec_d  = autoexec_q;
    data_d      = data_q;

    if (cmdbusy_i) begin
      // first collision is latched, later ones keep the old code
      if (any_access && cmderr_q == `DM_CMDERR_NONE) begin
        cmderr_d = `DM_CMDERR_BUSY;
      end
    end else begin
      if (wr_command_i) begin
        command_d   = wdata_i;
        cmd_valid_d = 1'b1;
      end
      // cmderr is write-one-to-clear
      if (wr_abstractcs_i) begin
        cmderr_d = cmderr_q & ~wdata_i[10:8];
      end
      if (wr_abstractauto_i) begin
        autoexec_d = wdata_i[`DM_DATA_COUNT-1:0];
      end
      if (wr_data_i) begin
        data_d[32*data_idx_i +: 32] = wdata_i;
      end
      // rerun the last command on a data access
      if (wr_data_i || rd_data_i) begin
        cmd_valid_d = autoexec_q[data_idx_i];
      end
    end

    // hart side has priority
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= `DM_CMDERR_NONE;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      autoexec_q  <= '0;
      data_q      <= '0;
    end else if (!dmactive_i) begin
      cmderr_q    <= `DM_CMDERR_NONE;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      autoexec_q  <= '0;
      data_q      <= '0;
    end else begin
      cmderr_q    <= cmderr_d;
      command_q   <= command_d;
      cmd_valid_q <= cmd_valid_d;
      autoexec_q  <= autoexec_d;
      data_q      <= data_d;
    end
  end

endmodule

/* src/dm_csrs.sv */
`timescale 1ns/1ps

module dm_csrs (
  input  logic              clk_i,
  input  logic              rst_ni,
  // DMI request
  input  logic              dmi_req_valid_i,
  output logic              dmi_req_ready_o,
  input  dm_pkg::dmi_addr_t dmi_req_addr_i,
  input  dm_pkg::dmi_op_t   dmi_req_op_i,
  input  dm_pkg::dm_word_t  dmi_req_data_i,
  // DMI response
  output logic              dmi_resp_valid_o,
  input  logic              dmi_resp_ready_i,
  output dm_pkg::dm_word_t  dmi_resp_data_o,
  // hart status and control
  input  dm_pkg::hart_vec_t halted_i,
  input  dm_pkg::hart_vec_t unavailable_i,
  input  dm_pkg::hart_vec_t resumeack_i,
  output dm_pkg::hart_vec_t haltreq_o,
  output dm_pkg::hart_vec_t resumereq_o,
  output logic              clear_resumeack_o,
  output logic              ndmreset_o,
  output logic              dmactive_o,
  // abstract command
  output logic              cmd_valid_o,
  output dm_pkg::dm_word_t  cmd_o,
  input  logic              cmdbusy_i,
  input  logic              cmderror_valid_i,
  input  dm_pkg::cmderr_t   cmderror_i,
  output dm_pkg::data_bus_t data_o,
  input  dm_pkg::data_bus_t data_i,
  input  logic              data_valid_i
);

  logic              queue_full, queue_empty, push;
  dm_pkg::dm_word_t  push_data, wdata;
  logic              wr_dmcontrol, wr_abstractcs, wr_command, wr_abstractauto;
  logic              wr_data, rd_data;
  dm_pkg::data_idx_t data_idx;
  dm_pkg::dm_word_t  dmcontrol, dmstatus, haltsum0, abstractcs, abstractauto;

  assign dmi_resp_valid_o = ~queue_empty;

  dm_dmi_decode i_decode (
    .clk_i, .rst_ni, .dmi_req_valid_i, .dmi_req_addr_i, .dmi_req_op_i, .dmi_req_data_i,
    .queue_full_i (queue_full), .dmcontrol_i (dmcontrol), .dmstatus_i (dmstatus),
    .haltsum0_i (haltsum0), .abstractcs_i (abstractcs), .abstractauto_i (abstractauto),
    .data_i (data_o), .dmi_req_ready_o, .wr_dmcontrol_o (wr_dmcontrol),
    .wr_abstractcs_o (wr_abstractcs), .wr_command_o (wr_command),
    .wr_abstractauto_o (wr_abstractauto), .wr_data_o (wr_data), .rd_data_o (rd_data),
    .data_idx_o (data_idx), .wdata_o (wdata), .push_o (push), .push_data_o (push_data)
  );

  dm_hart_ctrl i_hart_ctrl (
    .clk_i, .rst_ni, .wr_dmcontrol_i (wr_dmcontrol), .wdata_i (wdata), .halted_i,
    .unavailable_i, .resumeack_i, .dmcontrol_o (dmcontrol), .dmstatus_o (dmstatus),
    .haltsum0_o (haltsum0), .haltreq_o, .resumereq_o, .clear_resumeack_o, .ndmreset_o,
    .dmactive_o
  );

  dm_abstract_cmd i_abstract_cmd (
    .clk_i, .rst_ni, .dmactive_i (dmactive_o), .wr_abstractcs_i (wr_abstractcs),
    .wr_command_i (wr_command), .wr_abstractauto_i (wr_abstractauto), .wr_data_i (wr_data),
    .rd_data_i (rd_data), .data_idx_i (data_idx), .wdata_i (wdata), .cmdbusy_i,
    .cmderror_valid_i, .cmderror_i, .data_i, .data_valid_i, .abstractcs_o (abstractcs),
    .abstractauto_o (abstractauto), .cmd_o, .cmd_valid_o, .data_o
  );

  // response queue, pops are ignored while empty
  dm_resp_fifo i_resp_fifo (
    .clk_i, .rst_ni, .push_i (push), .data_i (push_data), .pop_i (dmi_resp_ready_i),
    .data_o (dmi_resp_data_o), .full_o (queue_full), .empty_o (queue_empty)
  );

endmodule

/* tb/dm_csrs_assert.sv */
`timescale 1ns/1ps

module dm_csrs_assert (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  dmi_req_valid_i,
  input dm_pkg::dmi_addr_t     dmi_req_addr_i,
  input dm_pkg::dmi_op_t       dmi_req_op_i,
  input dm_pkg::dm_word_t      dmi_req_data_i,
  input dm_pkg::decode_state_e dec_state_i,
  input logic                  push_i,
  input logic                  resp_valid_i,
  input logic                  resp_ready_i,
  input logic                  cmd_valid_i,
  input dm_pkg::hart_vec_t     haltreq_i,
  input dm_pkg::hart_vec_t     resumereq_i,
  input logic                  clear_resumeack_i,
  input logic                  ndmreset_i,
  input logic                  dmactive_i
);

  int unsigned fail_count = 0;
  logic [1:0]  resp_count;

  // words waiting in the response queue, counted from the DMI handshakes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_count <= 2'd0;
    end else begin
      resp_count <= resp_count + 2'(push_i) - 2'(resp_valid_i & resp_ready_i);
    end
  end

  // a stalled request holds its fields until it is accepted
  stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_state_i == dm_pkg::DEC_STALL |-> dmi_req_valid_i && $stable(dmi_req_addr_i) &&
      $stable(dmi_req_op_i) && $stable(dmi_req_data_i))
    else begin
      fail_count++;
      $error("stalled DMI request changed before acceptance");
    end

  cmd_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |=> !cmd_valid_i)
    else begin
      fail_count++;
      $error("cmd_valid_o lasted longer than one cycle");
    end

  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> resp_count < 2'd2)
    else begin
      fail_count++;
      $error("response pushed into a full queue");
    end

  // control outputs stay quiet while reset is held
  reset_idle: assert property (@(posedge clk_i)
    !rst_ni |-> !resp_valid_i && !cmd_valid_i && haltreq_i == '0 && resumereq_i == '0 &&
      !clear_resumeack_i && !ndmreset_i && !dmactive_i)
    else begin
      fail_count++;
      $error("control output active during reset");
    end

endmodule

bind dm_csrs dm_csrs_assert u_assert (
  .clk_i, .rst_ni, .dmi_req_valid_i, .dmi_req_addr_i, .dmi_req_op_i, .dmi_req_data_i,
  .dec_state_i (i_decode.state_q), .push_i (push), .resp_valid_i (dmi_resp_valid_o),
  .resp_ready_i (dmi_resp_ready_i), .cmd_valid_i (cmd_valid_o), .haltreq_i (haltreq_o),
  .resumereq_i (resumereq_o), .clear_resumeack_i (clear_resumeack_o),
  .ndmreset_i (ndmreset_o), .dmactive_i (dmactive_o)
);

/* tb/dm_csrs_tb.sv */
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_csrs_tb;

  // generous bound on the cycles that all tests take
  localparam int unsigned MaxCycles = 2000;

  logic              clk_i, rst_ni;
  logic              dmi_req_valid_i, dmi_req_ready_o;
  dm_pkg::dmi_addr_t dmi_req_addr_i;
  dm_pkg::dmi_op_t   dmi_req_op_i;
  dm_pkg::dm_word_t  dmi_req_data_i;
  logic              dmi_resp_valid_o, dmi_resp_ready_i;
  dm_pkg::dm_word_t  dmi_resp_data_o;
  dm_pkg::hart_vec_t halted_i, unavailable_i, resumeack_i, haltreq_o, resumereq_o;
  logic              clear_resumeack_o, ndmreset_o, dmactive_o;
  logic              cmd_valid_o, cmdbusy_i, cmderror_valid_i, data_valid_i;
  dm_pkg::dm_word_t  cmd_o;
  dm_pkg::cmderr_t   cmderror_i;
  dm_pkg::data_bus_t data_o, data_i;

  int unsigned       errors, checks, cycles, cmd_pulses;
  logic              clear_seen;
  dm_pkg::dm_word_t  data0_exp, data1_exp;

  dm_csrs dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == MaxCycles) begin
      $display("timeout: the tests did not finish within %0d cycles", MaxCycles);
      $display("Verification failed");
      $finish;
    end
  end

  // count cycles with cmd_valid_o high at the falling edge
  always @(negedge clk_i) begin
    if (cmd_valid_o === 1'b1) begin
      cmd_pulses++;
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  // --------------------------------------------------
  // DMI driver
  // --------------------------------------------------
  task automatic dmi_access(input dm_pkg::dmi_op_t op, input dm_pkg::dmi_addr_t addr,
                            input dm_pkg::dm_word_t wdata, output dm_pkg::dm_word_t rdata);
    logic accepted;
    accepted        = 1'b0;
    dmi_req_valid_i = 1'b1;
    dmi_req_op_i    = op;
    dmi_req_addr_i  = addr;
    dmi_req_data_i  = wdata;
    while (!accepted) begin
      @(negedge clk_i);
      accepted   = dmi_req_ready_o;
      clear_seen = clear_resumeack_o;
      @(posedge clk_i);
      #2;
    end
    dmi_req_valid_i = 1'b0;
    dmi_req_op_i    = `DM_OP_NOP;
    @(negedge clk_i);
    while (!dmi_resp_valid_o) begin
      @(negedge clk_i);
    end
    rdata = dmi_resp_data_o;
    // the word leaves on this edge with ready high
    @(posedge clk_i);
    #2;
  endtask

  task automatic dmi_write(input dm_pkg::dmi_addr_t addr, input dm_pkg::dm_word_t wdata);
    dm_pkg::dm_word_t resp;
    dmi_access(`DM_OP_WRITE, addr, wdata, resp);
    check("write response", resp, 32'h0);
  endtask

  task automatic dmi_read(input dm_pkg::dmi_addr_t addr, output dm_pkg::dm_word_t rdata);
    dmi_access(`DM_OP_READ, addr, 32'h0, rdata);
  endtask

  task automatic expect_reg(input string name, input dm_pkg::dmi_addr_t addr,
                            input dm_pkg::dm_word_t expected);
    dm_pkg::dm_word_t value;
    dmi_read(addr, value);
    check(name, value, expected);
  endtask

  function automatic dm_pkg::dm_word_t ctrl_word(input logic halt, input logic resume,
      input logic ack, input logic [9:0] sel, input logic active);
    return {halt, resume, 1'b0, ack, 2'b0, sel, 14'b0, 1'b0, active};
  endfunction

  // dmstatus of one selected hart with version 2 and authenticated
  function automatic dm_pkg::dm_word_t status_word(input logic halted, input logic running,
      input logic unavail, input logic nonexist, input logic resumeack, input logic havereset);
    dm_pkg::dm_word_t w;
    w        = 32'h0;
    w[3:0]   = 4'd2;
    w[7]     = 1'b1;
    w[9:8]   = {2{halted}};
    w[11:10] = {2{running}};
    w[13:12] = {2{unavail}};
    w[15:14] = {2{nonexist}};
    w[17:16] = {2{resumeack}};
    w[19:18] = {2{havereset}};
    return w;
  endfunction

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic test_reset();
    @(negedge clk_i);
    check("dmi_resp_valid_o", 32'(dmi_resp_valid_o), 32'h0);
    check("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'h1);
    check("dmactive_o", 32'(dmactive_o), 32'h0);
    check("ndmreset_o", 32'(ndmreset_o), 32'h0);
    @(posedge clk_i);
    #2;
    expect_reg("dmcontrol", `DM_ADDR_DMCONTROL, 32'h0);
    expect_reg("dmstatus", `DM_ADDR_DMSTATUS,
               status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
  endtask

  task automatic test_halt();
    dmi_write(`DM_ADDR_DMCONTROL, ctrl_word(1'b0, 1'b0, 1'b0, 10'd0, 1'b1));
    check("dmactive_o", 32'(dmactive_o), 32'h1);
    dmi_write(`DM_ADDR_DMCONTROL, ctrl_word(1'b1, 1'b0, 1'b0, 10'd2, 1'b1));
    check("haltreq_o", 32'(haltreq_o), 32'h4);
    expect_reg("dmcontrol", `DM_ADDR_DMCONTROL, ctrl_word(1'b1, 1'b0, 1'b0, 10'd2, 1'b1));
    halted_i = 4'b0100;
    expect_reg("dmstatus", `DM_ADDR_DMSTATUS,
               status_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    expect_reg("haltsum0", `DM_ADDR_HALTSUM0, 32'h4);
    // ack the reset of hart 2 and drop haltreq
    dmi_write(`DM_ADDR_DMCONTROL, ctrl_word(1'b0, 1'b0, 1'b1, 10'd2, 1'b1));
    expect_reg("dmstatus", `DM_ADDR_DMSTATUS,
               status_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
    dmi_write(`DM_ADDR_DMCONTROL, ctrl_word(1'b1, 1'b0, 1'b0, 10'd5, 1'b1));
    check("haltreq_o", 32'(haltreq_o), 32'h0);
    expect_reg("dmstatus", `DM_ADDR_DMSTATUS,
               status_word(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
    halted_i = '0;
    // ndmreset sets every havereset flag again
    dmi_write(`DM_ADDR_DMCONTROL, ctrl_word(1'b0, 1'b0, 1'b0, 10'd2, 1'b1) | 32'h2);
    check("ndmreset_o", 32'(ndmreset_o), 32'h1);
    dmi_write(`DM_ADDR_DMCONTROL, ctrl_word(1'b0, 1'b0, 1'b0, 10'd2, 1'b1));
    check("ndmreset_o", 32'(ndmreset_o), 32'h0);
    expect_reg("dmstatus", `DM_ADDR_DMSTATUS,
               status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
  endtask

  task automatic test_resume();
    dmi_write(`DM_ADDR_DMCONTROL, ctrl_word(1'b0, 1'b1, 1'b0, 10'd1, 1'b1));
    check("clear_resumeack_o", 32'(clear_seen), 32'h1);
    check("resumereq_o", 32'(resumereq_o), 32'h2);
    resumeack_i = 4'b0010;
    @(posedge clk_i);
    #2;
    check("resumereq_o", 32'(resumereq_o), 32'h0);
    expect_reg("dmstatus", `DM_ADDR_DMSTATUS,
               status_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
    expect_reg("dmcontrol", `DM_ADDR_DMCONTROL, ctrl_word(1'b0, 1'b0, 1'b0, 10'd1, 1'b1));
    resumeack_i = '0;
  endtask

  task automatic test_abstract();
    dm_pkg::dm_word_t cmd_a;
    cmd_a      = $urandom;
    cmd_pulses = 0;
    dmi_write(`DM_ADDR_COMMAND, cmd_a);
    check("cmd_valid_o pulses", cmd_pulses, 32'd1);
    check("cmd_o", cmd_o, cmd_a);
    // busy collision latches cmderr and keeps the old command
    cmdbusy_i  = 1'b1;
    cmd_pulses = 0;
    dmi_write(`DM_ADDR_COMMAND, ~cmd_a);
    check("cmd_valid_o pulses", cmd_pulses, 32'd0);
    check("cmd_o", cmd_o, cmd_a);
    expect_reg("abstractcs", `DM_ADDR_ABSTRACTCS, 32'h0000_1102);
    cmdbusy_i = 1'b0;
    dmi_write(`DM_ADDR_ABSTRACTCS, 32'h0000_0700);
    expect_reg("abstractcs", `DM_ADDR_ABSTRACTCS, 32'h0000_0002);
    cmderror_valid_i = 1'b1;
    cmderror_i       = 3'd3;
    @(posedge clk_i);
    #2;
    cmderror_valid_i = 1'b0;
    expect_reg("abstractcs", `DM_ADDR_ABSTRACTCS, 32'h0000_0302);
    dmi_write(`DM_ADDR_DMCONTROL, 32'h0);
    check("dmactive_o", 32'(dmactive_o), 32'h0);
    expect_reg("abstractcs", `DM_ADDR_ABSTRACTCS, 32'h0000_0002);
    check("cmd_o", cmd_o, 32'h0);
    dmi_write(`DM_ADDR_DMCONTROL, ctrl_word(1'b0, 1'b0, 1'b0, 10'd0, 1'b1));
  endtask

  task automatic test_data();
    data0_exp = $urandom;
    data1_exp = $urandom;
    dmi_write(`DM_ADDR_DATA0, data0_exp);
    dmi_write(`DM_ADDR_DATA0 + 7'd1, data1_exp);
    expect_reg("data0", `DM_ADDR_DATA0, data0_exp);
    expect_reg("data1", `DM_ADDR_DATA0 + 7'd1, data1_exp);
    check("data_o[31:0]", data_o[31:0], data0_exp);
    check("data_o[63:32]", data_o[63:32], data1_exp);
    // autoexec on data1 only
    dmi_write(`DM_ADDR_ABSTRACTAUTO, 32'h2);
    expect_reg("abstractauto", `DM_ADDR_ABSTRACTAUTO, 32'h2);
    cmd_pulses = 0;
    expect_reg("data1", `DM_ADDR_DATA0 + 7'd1, data1_exp);
    check("cmd_valid_o pulses", cmd_pulses, 32'd1);
    cmd_pulses = 0;
    expect_reg("data0", `DM_ADDR_DATA0, data0_exp);
    check("cmd_valid_o pulses", cmd_pulses, 32'd0);
    dmi_write(`DM_ADDR_ABSTRACTAUTO, 32'h0);
    data0_exp    = $urandom;
    data1_exp    = $urandom;
    data_i       = {data1_exp, data0_exp};
    data_valid_i = 1'b1;
    @(posedge clk_i);
    #2;
    data_valid_i = 1'b0;
    expect_reg("data0", `DM_ADDR_DATA0, data0_exp);
    expect_reg("data1", `DM_ADDR_DATA0 + 7'd1, data1_exp);
  endtask

  task automatic test_backpressure();
    dmi_resp_ready_i = 1'b0;
    dmi_req_valid_i  = 1'b1;
    dmi_req_op_i     = `DM_OP_READ;
    dmi_req_addr_i   = `DM_ADDR_DATA0;
    @(negedge clk_i);
    check("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'h1);
    @(posedge clk_i);
    #2;
    dmi_req_addr_i = `DM_ADDR_DATA0 + 7'd1;
    @(negedge clk_i);
    check("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'h1);
    @(posedge clk_i);
    #2;
    // third request waits on the full queue
    dmi_req_addr_i = `DM_ADDR_ABSTRACTCS;
    repeat (2) begin
      @(negedge clk_i);
      check("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'h0);
      @(posedge clk_i);
      #2;
    end
    dmi_resp_ready_i = 1'b1;
    @(negedge clk_i);
    check("dmi_resp_valid_o", 32'(dmi_resp_valid_o), 32'h1);
    check("dmi_resp_data_o", dmi_resp_data_o, data0_exp);
    @(posedge clk_i);
    #2;
    @(negedge clk_i);
    check("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'h1);
    check("dmi_resp_data_o", dmi_resp_data_o, data1_exp);
    @(posedge clk_i);
    #2;
    dmi_req_valid_i = 1'b0;
    @(negedge clk_i);
    check("dmi_resp_data_o", dmi_resp_data_o, 32'h0000_0002);
    @(posedge clk_i);
    #2;
    @(negedge clk_i);
    check("dmi_resp_valid_o", 32'(dmi_resp_valid_o), 32'h0);
    @(posedge clk_i);
    #2;
  endtask

  initial begin
    errors           = 0;
    checks           = 0;
    cycles           = 0;
    cmd_pulses       = 0;
    clear_seen       = 1'b0;
    void'($urandom(32'hb39c_2ee1));
    rst_ni           = 1'b1;
    dmi_req_valid_i  = 1'b0;
    dmi_req_addr_i   = '0;
    dmi_req_op_i     = `DM_OP_NOP;
    dmi_req_data_i   = '0;
    dmi_resp_ready_i = 1'b1;
    halted_i         = '0;
    unavailable_i    = '0;
    resumeack_i      = '0;
    cmdbusy_i        = 1'b0;
    cmderror_valid_i = 1'b0;
    cmderror_i       = '0;
    data_i           = '0;
    data_valid_i     = 1'b0;
    #2;
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    test_reset();
    test_halt();
    test_resume();
    test_abstract();
    test_data();
    test_backpressure();

    errors += dut0.u_assert.fail_count;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* dm_csrs.f */
+incdir+src
src/dm_pkg.sv
src/dm_resp_fifo.sv
src/dm_dmi_decode.sv
src/dm_hart_ctrl.sv
src/dm_abstract_cmd.sv
src/dm_csrs.sv
tb/dm_csrs_assert.sv
tb/dm_csrs_tb.sv
